/* files.f */
+incdir+include
rtl/axi_pkg.sv
rtl/sram_pkg.sv
rtl/sram_ctrl_fsm.sv
rtl/burst_counter.sv
rtl/sram_model.sv
rtl/sram_wrapper_top.sv
test/sram_wrapper_assert.sv
test/tb_sram_wrapper.sv

/* include/sram_consts.svh */
`ifndef SRAM_CONSTS_SVH
`define SRAM_CONSTS_SVH

// word address into the scratch memory, 16 Ki words.
`define SRAM_ADDR_BITS 14
`define SRAM_DEPTH (1 << `SRAM_ADDR_BITS)

`define AXI_ADDR_BITS 16
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
`define AXI_ID_BITS 4
// beats per burst are the len field plus one.
`define AXI_LEN_BITS 4

`endif

/* rtl/axi_pkg.sv */
`default_nettype none

`include "sram_consts.svh"

package axi_pkg;

  // shared by the aw and ar channels.
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;  // byte address, word aligned.
    logic [`AXI_LEN_BITS-1:0]  len;
  } addr_req_t;

  typedef struct packed {
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
  } w_beat_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_DATA_BITS-1:0] data;
    logic                      last;
  } r_beat_t;

  // the response is always OKAY, so only the id travels.
  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
  } b_resp_t;

endpackage

`default_nettype wire

/* rtl/burst_counter.sv */
`default_nettype none

`include "sram_consts.svh"

module burst_counter (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       load,
  input  logic                       step,
  input  logic                       req_sel,  // high selects the write request.
  input  axi_pkg::addr_req_t         aw_req,
  input  axi_pkg::addr_req_t         ar_req,
  output logic [`SRAM_ADDR_BITS-1:0] addr,
  output logic [`AXI_ID_BITS-1:0]    id,
  output logic                       last
);

  axi_pkg::addr_req_t         req;
  logic [`SRAM_ADDR_BITS-1:0] base;
  logic [`AXI_LEN_BITS-1:0]   len;
  logic [`AXI_LEN_BITS-1:0]   beat;

  assign req = req_sel ? aw_req : ar_req;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      len  <= '0;
      beat <= '0;
    end else if (load) begin
      len  <= req.len;
      beat <= '0;
    end else if (step) begin
      beat <= beat + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      base <= req.addr[`AXI_ADDR_BITS-1:2];  // drop the byte offset.
      id   <= req.id;
    end
  end

  // the sum wraps at the top of the memory.
  assign addr = base + `SRAM_ADDR_BITS'(beat);
  assign last = (beat == len);

endmodule

`default_nettype wire

/* rtl/sram_ctrl_fsm.sv */
`default_nettype none

module sram_ctrl_fsm (
  input  logic                clk,
  input  logic                rstn,
  input  logic                aw_valid,
  input  logic                w_valid,
  input  logic                w_last,
  input  logic                b_ready,
  input  logic                ar_valid,
  input  logic                r_ready,
  input  logic                burst_last,
  output logic                aw_ready,
  output logic                w_ready,
  output logic                b_valid,
  output logic                ar_ready,
  output logic                r_valid,
  output logic                load,
  output logic                step,
  output logic                req_sel,
  output sram_pkg::sram_ctl_t sram_ctl
);

  sram_pkg::ctrl_state_t state;
  sram_pkg::ctrl_state_t next_state;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= sram_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    aw_ready   = 1'b0;
    w_ready    = 1'b0;
    b_valid    = 1'b0;
    ar_ready   = 1'b0;
    r_valid    = 1'b0;
    load       = 1'b0;
    step       = 1'b0;
    req_sel    = 1'b0;
    sram_ctl   = '0;

    case (state)
      sram_pkg::IDLE: begin
        aw_ready = 1'b1;
        ar_ready = ~aw_valid;  // a pending write goes first.
        req_sel  = aw_valid;
        if (aw_valid) begin
          load       = 1'b1;
          next_state = sram_pkg::WR_DATA;
        end else if (ar_valid) begin
          load       = 1'b1;
          next_state = sram_pkg::RD_FETCH;
        end
      end

      sram_pkg::RD_FETCH: begin
        // the counter address is settled here, rdata follows next cycle.
        sram_ctl.cs = 1'b1;
        next_state  = sram_pkg::RD_DATA;
      end

      sram_pkg::RD_DATA: begin
        r_valid = 1'b1;
        if (r_ready) begin
          if (burst_last) begin
            next_state = sram_pkg::IDLE;
          end else begin
            step       = 1'b1;
            next_state = sram_pkg::RD_FETCH;
          end
        end
      end

      sram_pkg::WR_DATA: begin
        w_ready = 1'b1;
        if (w_valid) begin
          sram_ctl.cs = 1'b1;
          sram_ctl.we = 1'b1;
          step        = 1'b1;
          if (w_last) begin
            next_state = sram_pkg::WR_RESP;
          end
        end
      end

      sram_pkg::WR_RESP: begin
        b_valid = 1'b1;
        if (b_ready) next_state = sram_pkg::IDLE;
      end

      default: next_state = sram_pkg::IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/sram_model.sv */
`default_nettype none

`include "sram_consts.svh"

module sram_model (
  input  logic                       clk,
  input  sram_pkg::sram_ctl_t        sram_ctl,
  input  logic [`SRAM_ADDR_BITS-1:0] addr,
  input  logic [`AXI_DATA_BITS-1:0]  wdata,
  input  logic [`AXI_STRB_BITS-1:0]  strb,
  output logic [`AXI_DATA_BITS-1:0]  rdata
);

  logic [`AXI_DATA_BITS-1:0] mem [`SRAM_DEPTH];

  // a write leaves rdata as it was, as the macro does.
  always_ff @(posedge clk) begin
    if (sram_ctl.cs) begin
      if (sram_ctl.we) begin
        for (int i = 0; i < `AXI_STRB_BITS; i++) begin
          if (strb[i]) mem[addr][8*i +: 8] <= wdata[8*i +: 8];
        end
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_pkg.sv */
`default_nettype none

package sram_pkg;

  typedef enum logic [2:0] {
    IDLE,
    RD_FETCH,
    RD_DATA,
    WR_DATA,
    WR_RESP
  } ctrl_state_t;

  // cs alone reads, cs with we writes under the byte strobes.
  typedef struct packed {
    logic cs;
    logic we;
  } sram_ctl_t;

endpackage

`default_nettype wire

/* rtl/sram_wrapper_top.sv */
`default_nettype none

`include "sram_consts.svh"

module sram_wrapper_top (
  input  logic               clk,
  input  logic               rstn,
  input  logic               aw_valid,
  input  axi_pkg::addr_req_t aw,
  output logic               aw_ready,
  input  logic               w_valid,
  input  axi_pkg::w_beat_t   w,
  output logic               w_ready,
  output logic               b_valid,
  output axi_pkg::b_resp_t   b,
  input  logic               b_ready,
  input  logic               ar_valid,
  input  axi_pkg::addr_req_t ar,
  output logic               ar_ready,
  output logic               r_valid,
  output axi_pkg::r_beat_t   r,
  input  logic               r_ready
);

  logic                       load;
  logic                       step;
  logic                       req_sel;
  sram_pkg::sram_ctl_t        sram_ctl;
  logic [`SRAM_ADDR_BITS-1:0] cnt_addr;
  logic [`AXI_ID_BITS-1:0]    cnt_id;
  logic                       cnt_last;
  logic [`AXI_DATA_BITS-1:0]  rdata;

  sram_ctrl_fsm i_fsm (
    .clk       (clk),
    .rstn      (rstn),
    .aw_valid  (aw_valid),
    .w_valid   (w_valid),
    .w_last    (w.last),
    .b_ready   (b_ready),
    .ar_valid  (ar_valid),
    .r_ready   (r_ready),
    .burst_last(cnt_last),
    .aw_ready  (aw_ready),
    .w_ready   (w_ready),
    .b_valid   (b_valid),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .load      (load),
    .step      (step),
    .req_sel   (req_sel),
    .sram_ctl  (sram_ctl)
  );

  burst_counter i_cnt (
    .clk    (clk),
    .rstn   (rstn),
    .load   (load),
    .step   (step),
    .req_sel(req_sel),
    .aw_req (aw),
    .ar_req (ar),
    .addr   (cnt_addr),
    .id     (cnt_id),
    .last   (cnt_last)
  );

  sram_model i_mem (
    .clk     (clk),
    .sram_ctl(sram_ctl),
    .addr    (cnt_addr),
    .wdata   (w.data),
    .strb    (w.strb),
    .rdata   (rdata)
  );

  // both responses echo the id captured with the request.
  assign r.id   = cnt_id;
  assign r.data = rdata;
  assign r.last = cnt_last;
  assign b.id   = cnt_id;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_sram_wrapper -o tb_sram_wrapper &&
./obj_dir/tb_sram_wrapper || { echo "simulation run reported failure"; exit 1; }

/* test/sram_wrapper_assert.sv */
`default_nettype none

module sram_wrapper_assert (
  input wire logic             clk,
  input wire logic             rstn,
  input wire logic             w_valid,
  input wire logic             w_ready,
  input wire axi_pkg::w_beat_t w,
  input wire logic             b_valid,
  input wire logic             b_ready,
  input wire axi_pkg::b_resp_t b,
  input wire logic             r_valid,
  input wire logic             r_ready,
  input wire axi_pkg::r_beat_t r
);

  timeunit 1ns;
  timeprecision 100ps;

  r_hold: assert property (@(posedge clk) disable iff (!rstn)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r channel changed while stalled");

  b_hold: assert property (@(posedge clk) disable iff (!rstn)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else $error("b channel changed while stalled");

  // the FSM is in one burst at a time, so these two never overlap.
  w_r_exclusive: assert property (@(posedge clk) disable iff (!rstn)
    !(w_ready && r_valid))
    else $error("w_ready and r_valid high together");

  b_after_last: assert property (@(posedge clk) disable iff (!rstn)
    $rose(b_valid) |-> $past(w_valid && w_ready && w.last))
    else $error("b_valid rose without a last write beat");

endmodule

bind sram_wrapper_top sram_wrapper_assert i_assert (
  .clk    (clk),
  .rstn   (rstn),
  .w_valid(w_valid),
  .w_ready(w_ready),
  .w      (w),
  .b_valid(b_valid),
  .b_ready(b_ready),
  .b      (b),
  .r_valid(r_valid),
  .r_ready(r_ready),
  .r      (r)
);

`default_nettype wire

/* test/tb_sram_wrapper.sv */
`default_nettype none

`include "sram_consts.svh"

module tb_sram_wrapper;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TXN    = 34;  // 8 + 8 write and read pairs plus one overlapped pair.
  localparam int MAX_CYCLES = NUM_TXN * 16 * 6 + 200;

  logic clk;
  logic rstn;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready;
  axi_pkg::addr_req_t aw, ar;
  axi_pkg::w_beat_t   w;
  axi_pkg::b_resp_t   b;
  axi_pkg::r_beat_t   r;

  logic [`AXI_DATA_BITS-1:0] shadow [`SRAM_DEPTH];
  axi_pkg::r_beat_t exp_r [$];
  axi_pkg::b_resp_t exp_b [$];
  int cycles;

  sram_wrapper_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_r(input axi_pkg::r_beat_t got, input axi_pkg::r_beat_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED r got id %h data %h last %h expected id %h data %h last %h",
                         got.id, got.data, got.last, exp.id, exp.data, exp.last));
    end
  endtask

  task automatic check_b(input axi_pkg::b_resp_t got, input axi_pkg::b_resp_t exp);
    if (got !== exp) fail_run($sformatf("FAILED b.id got %h expected %h", got.id, exp.id));
  endtask

  function automatic logic [`AXI_DATA_BITS-1:0] merge_bytes(
    input logic [`AXI_DATA_BITS-1:0] old_word,
    input logic [`AXI_DATA_BITS-1:0] new_word,
    input logic [`AXI_STRB_BITS-1:0] strb
  );
    logic [`AXI_DATA_BITS-1:0] word;
    word = old_word;
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      if (strb[i]) word[8*i +: 8] = new_word[8*i +: 8];
    end
    return word;
  endfunction

  // beat n of a burst lands on the next word, wrapping at the top of memory.
  function automatic logic [`SRAM_ADDR_BITS-1:0] word_addr(input axi_pkg::addr_req_t req,
                                                          input int n);
    return req.addr[`AXI_ADDR_BITS-1:2] + `SRAM_ADDR_BITS'(n);
  endfunction

  function automatic axi_pkg::r_beat_t expected_beat(input axi_pkg::addr_req_t req, input int n);
    axi_pkg::r_beat_t beat;
    beat.id   = req.id;
    beat.data = shadow[word_addr(req, n)];
    beat.last = (n == int'(req.len));
    return beat;
  endfunction

  function automatic axi_pkg::addr_req_t random_req();
    axi_pkg::addr_req_t req;
    req.id   = `AXI_ID_BITS'($urandom());
    req.addr = {`SRAM_ADDR_BITS'($urandom()), 2'b00};
    req.len  = `AXI_LEN_BITS'($urandom());
    return req;
  endfunction

  task automatic check_reset_flags();
    check_flag("r_valid", r_valid, 1'b0);
    check_flag("b_valid", b_valid, 1'b0);
    check_flag("w_ready", w_ready, 1'b0);
    check_flag("aw_ready", aw_ready, 1'b1);
  endtask

  task automatic write_burst(input axi_pkg::addr_req_t req, input logic full_strb);
    axi_pkg::w_beat_t beat;
    logic [`SRAM_ADDR_BITS-1:0] waddr;
    logic done;
    @(negedge clk);
    aw_valid = 1'b1;
    aw       = req;
    do @(posedge clk); while (!aw_ready);
    exp_b.push_back(req.id);
    @(negedge clk);
    aw_valid = 1'b0;
    for (int n = 0; n <= int'(req.len); n++) begin
      beat.data = $urandom();
      beat.strb = full_strb ? '1 : `AXI_STRB_BITS'($urandom());
      beat.last = (n == int'(req.len));
      w_valid   = 1'b1;
      w         = beat;
      do @(posedge clk); while (!w_ready);
      waddr         = word_addr(req, n);
      shadow[waddr] = merge_bytes(shadow[waddr], beat.data, beat.strb);
      @(negedge clk);
    end
    w_valid = 1'b0;
    do begin
      b_ready = ($urandom_range(0, 3) != 0);  // stall b about one cycle in four.
      @(posedge clk);
      done = b_valid && b_ready;
      @(negedge clk);
    end while (!done);
    b_ready = 1'b0;
  endtask

  task automatic read_burst(input axi_pkg::addr_req_t req);
    int got;
    @(negedge clk);
    ar_valid = 1'b1;
    ar       = req;
    do @(posedge clk); while (!ar_ready);
    // the write ahead of this read has finished, so the shadow is current.
    for (int n = 0; n <= int'(req.len); n++) exp_r.push_back(expected_beat(req, n));
    @(negedge clk);
    ar_valid = 1'b0;
    got      = 0;
    while (got <= int'(req.len)) begin
      r_ready = ($urandom_range(0, 3) != 0);
      @(posedge clk);
      if (r_valid && r_ready) got++;
      @(negedge clk);
    end
    r_ready = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rstn) begin
      if (ar_valid && ar_ready && aw_valid) fail_run("a read was accepted over a pending write");
      if (r_valid && r_ready) begin
        if (exp_r.size() == 0) fail_run("an R beat arrived with no read beat outstanding");
        else check_r(r, exp_r.pop_front());
      end
      if (b_valid && b_ready) begin
        if (exp_b.size() == 0) fail_run("a B response arrived with no write outstanding");
        else check_b(b, exp_b.pop_front());
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) fail_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  initial begin
    axi_pkg::addr_req_t reqs [8];
    axi_pkg::addr_req_t rd;
    void'($urandom(32'had8d9097));
    rstn     = 1'b0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    repeat (16) begin
      @(negedge clk);
      check_reset_flags();
    end
    rstn = 1'b1;
    @(negedge clk);
    check_reset_flags();

    foreach (reqs[i]) begin
      reqs[i] = random_req();
      write_burst(reqs[i], 1'b1);
      rd    = reqs[i];
      rd.id = ~rd.id;  // a fresh id so the echo is checked on both channels.
      read_burst(rd);
    end

    // partial strobes over words that are already written.
    foreach (reqs[i]) begin
      reqs[i].id = `AXI_ID_BITS'($urandom());
      write_burst(reqs[i], 1'b0);
      rd    = reqs[i];
      rd.id = ~rd.id;
      read_burst(rd);
    end

    rd    = random_req();
    reqs[0] = rd;
    rd.id = ~rd.id;
    fork
      write_burst(reqs[0], 1'b1);
      read_burst(rd);
    join

    // an idle slave sends no further beat and has both request channels open again.
    r_ready = 1'b1;
    b_ready = 1'b1;
    repeat (4) @(negedge clk);
    check_flag("aw_ready", aw_ready, 1'b1);
    check_flag("ar_ready", ar_ready, 1'b1);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
